// File: all.f
common/csr_pkg.sv
rtl/csr_decode.sv
rtl/csr_req_fifo.sv
csr/csr_data.sv
csr/csr_unit.sv
rtl/csr_top.sv
sim/tb_clock.sv
sim/csr_tb.sv

// File: sim/csr_tb.sv
/*
 * CSR subsystem testbench
 * Random CSR traffic against a reference model, FPU port, counters, back-pressure
 */
module csr_tb;
    import csr_pkg::*;

    typedef struct packed {
        logic        cyc;
        logic [2:0]  frm;
        logic        err;
        logic [1:0]  wid;
        logic [31:0] data;
    } exp_t;

    logic        clk, reset, req_valid, req_ready;
    logic [31:0] req_instr, req_rs1_data;
    logic [1:0]  req_wid, fpu_flags_wid, fpu_frm_wid, resp_wid;
    logic        fpu_flags_valid, resp_valid, resp_ready, resp_error;
    logic [4:0]  fpu_flags;
    logic [2:0]  fpu_frm;
    logic [31:0] resp_data;

    logic [31:0] lfsr;
    logic [7:0]  m_fcsr [4];
    logic [31:0] m_scratch, m_count, last_cycle;
    exp_t        exp_q[$];
    logic        bp_mode;
    int          hold_left;

    tb_clock u_clock (.clk(clk));

    csr_top UUT (.*);

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic logic [31:0] csr_instr(input logic [11:0] addr, input logic [4:0] field,
                                              input logic [2:0] f3);
        return {addr, field, f3, 5'd1, OPCODE_SYSTEM};
    endfunction

    function automatic logic [11:0] pick_addr(input logic [2:0] sel);
        case (sel)
            3'd0:    return CSR_MSCRATCH;
            3'd1:    return CSR_FFLAGS;
            3'd2:    return CSR_FRM;
            3'd3:    return CSR_FCSR;
            3'd4:    return CSR_MINSTRET;
            3'd5:    return CSR_MCYCLE;
            3'd6:    return CSR_WARP_ID;
            default: return CSR_MVENDORID;
        endcase
    endfunction

    // Reference read, returns 0 for an unsupported address
    function automatic logic read_model(input logic [11:0] addr, input logic [1:0] wid,
                                        output logic [31:0] data);
        data = '0;
        case (addr)
            CSR_FFLAGS:    data = {27'd0, m_fcsr[wid][4:0]};
            CSR_FRM:       data = {29'd0, m_fcsr[wid][7:5]};
            CSR_FCSR:      data = {24'd0, m_fcsr[wid]};
            CSR_MSCRATCH:  data = m_scratch;
            CSR_MINSTRET:  data = m_count;
            CSR_MCYCLE, CSR_MCYCLEH, CSR_MINSTRETH: data = '0;
            CSR_MISA:      data = MISA_VALUE;
            CSR_MVENDORID: data = VENDOR_ID;
            CSR_MARCHID:   data = ARCH_ID;
            CSR_CORE_ID:   data = CORE_ID;
            CSR_WARP_ID:   data = {30'd0, wid};
            CSR_NUM_WARPS: data = NUM_WARPS;
            default:       return 1'b0;
        endcase
        return 1'b1;
    endfunction

    task automatic send(input logic [31:0] instr, input logic [1:0] wid, input logic [31:0] rs1);
        logic [11:0] addr;
        logic [2:0]  f3;
        logic [4:0]  field;
        logic        illegal, writes, known;
        logic [31:0] operand, old_val, new_val;
        exp_t        e;
        int          waited;
        addr    = instr[31:20];
        f3      = instr[14:12];
        field   = instr[19:15];
        illegal = (instr[6:0] != OPCODE_SYSTEM) || f3 == 3'd0 || f3 == 3'd4;
        // Set or clear with a zero source is a pure read
        writes  = !((f3 == 3'd2 || f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) && field == 5'd0);
        operand = f3[2] ? {27'd0, field} : rs1;
        known   = read_model(addr, wid, old_val);
        e.err   = illegal || !known || (writes && addr[11:10] == 2'b11);
        e.data  = e.err ? 32'd0 : old_val;
        e.wid   = wid;
        e.cyc   = !e.err && addr == CSR_MCYCLE;
        if (!e.err) begin
            case (f3)
                3'd2, 3'd6: new_val = old_val | operand;
                3'd3, 3'd7: new_val = old_val & ~operand;
                default:    new_val = operand;
            endcase
            if (writes) begin
                case (addr)
                    CSR_FFLAGS:   m_fcsr[wid][4:0] = new_val[4:0];
                    CSR_FRM:      m_fcsr[wid][7:5] = new_val[2:0];
                    CSR_FCSR:     m_fcsr[wid] = new_val[7:0];
                    CSR_MSCRATCH: m_scratch = new_val;
                    default: ;
                endcase
            end
            m_count++;
        end
        e.frm = m_fcsr[wid][7:5];
        exp_q.push_back(e);
        req_valid    = 1'b1;
        req_instr    = instr;
        req_wid      = wid;
        req_rs1_data = rs1;
        waited       = 0;
        @(negedge clk);
        while (!req_ready) begin
            waited++;
            if (waited > 500) abort_run("Timed out waiting for req_ready");
            else @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic random_op(input int sel_bits);
        logic [11:0] addr;
        logic [2:0]  f3;
        logic [4:0]  field;
        addr  = pick_addr(3'(take_bits(sel_bits)));
        f3    = 3'(take_bits(3));
        if (f3 == 3'd0 || f3 == 3'd4) f3 = f3 + 3'd1;
        field = 5'(take_bits(5));
        send(csr_instr(addr, field, f3), 2'(take_bits(2)), take_bits(32));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > 2000) abort_run("Timed out waiting for outstanding responses");
            else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic pulse_flags(input logic [1:0] wid, input logic [4:0] flags);
        fpu_flags_valid = 1'b1;
        fpu_flags_wid   = wid;
        fpu_flags       = flags;
        m_fcsr[wid][4:0] = m_fcsr[wid][4:0] | flags;
        @(posedge clk);
        #1;
        fpu_flags_valid = 1'b0;
    endtask

    // resp_ready gaps drawn at the edge, driven with the FPU lookup just after it
    always @(posedge clk) begin : gaps
        logic next_ready;
        next_ready = 1'b1;
        if (bp_mode) begin
            if (hold_left == 0) begin
                next_ready = take_bits(1);
                hold_left  = take_bits(4);
            end else begin
                next_ready = resp_ready;
                hold_left--;
            end
        end
        #1;
        if (resp_valid) fpu_frm_wid = resp_wid;
        resp_ready = next_ready;
    end

    always @(negedge clk) begin : monitor
        exp_t e;
        if (!reset && resp_valid && resp_ready) begin
            assert (exp_q.size() != 0) else abort_run("Response arrived with nothing outstanding");
            e = exp_q.pop_front();
            assert (resp_wid == e.wid)
                else abort_run($sformatf("FAIL resp_wid got %h expected %h", resp_wid, e.wid));
            assert (resp_error == e.err)
                else abort_run($sformatf("FAIL resp_error got %h expected %h", resp_error, e.err));
            assert (e.cyc || resp_data == e.data)
                else abort_run($sformatf("FAIL resp_data got %h expected %h", resp_data, e.data));
            assert (!e.cyc || resp_data > last_cycle)
                else abort_run($sformatf("FAIL resp_data got %h expected above %h",
                                         resp_data, last_cycle));
            assert (fpu_frm == e.frm)
                else abort_run($sformatf("FAIL fpu_frm got %h expected %h", fpu_frm, e.frm));
            if (e.cyc) last_cycle = resp_data;
        end
    end

    initial begin
        lfsr = 32'h89bb;
        reset = 1'b1;
        req_valid = 1'b0;
        req_instr = '0;
        req_wid = '0;
        req_rs1_data = '0;
        fpu_flags_valid = 1'b0;
        fpu_flags_wid = '0;
        fpu_flags = '0;
        fpu_frm_wid = '0;
        resp_ready = 1'b1;
        bp_mode = 1'b0;
        hold_left = 0;
        for (int w = 0; w < 4; w++) m_fcsr[w] = '0;
        m_scratch = MSCRATCH_RESET;
        m_count = '0;
        last_cycle = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        assert (!resp_valid && req_ready) else abort_run("Handshake outputs wrong after reset");

        // Identity reads, read-only targets with x0
        send(csr_instr(CSR_MVENDORID, 5'd0, 3'd2), 2'd1, 32'hffff_ffff);
        send(csr_instr(CSR_MARCHID, 5'd0, 3'd3), 2'd2, 32'hffff_ffff);
        send(csr_instr(CSR_MISA, 5'd0, 3'd6), 2'd0, '0);
        send(csr_instr(CSR_CORE_ID, 5'd0, 3'd7), 2'd3, '0);
        send(csr_instr(CSR_NUM_WARPS, 5'd0, 3'd2), 2'd0, '0);
        for (int w = 0; w < 4; w++) send(csr_instr(CSR_WARP_ID, 5'd0, 3'd2), 2'(w), '0);

        repeat (40) random_op(2);

        // Error cases; the last one flips opcode bit 6 to get 0110011
        send(csr_instr(CSR_MVENDORID, 5'd3, 3'd1), 2'd0, 32'h1234_5678);
        send(csr_instr(CSR_MARCHID, 5'd1, 3'd6), 2'd1, '0);
        send(csr_instr(12'h7c0, 5'd2, 3'd1), 2'd2, 32'h5);
        send(csr_instr(CSR_MSCRATCH, 5'd2, 3'd4), 2'd3, 32'h5);
        send(csr_instr(CSR_MSCRATCH, 5'd2, 3'd1) ^ 32'h40, 2'd0, 32'h5);
        send(csr_instr(CSR_MSCRATCH, 5'd0, 3'd2), 2'd0, '0);
        drain();

        for (int w = 0; w < 4; w++) pulse_flags(2'(w), 5'(take_bits(5)));
        pulse_flags(2'd2, 5'h11);
        for (int w = 0; w < 4; w++) send(csr_instr(CSR_FFLAGS, 5'd0, 3'd2), 2'(w), '0);

        repeat (3) send(csr_instr(CSR_MCYCLE, 5'd0, 3'd2), 2'd1, '0);
        send(csr_instr(CSR_MINSTRET, 5'd0, 3'd2), 2'd0, '0);
        send(csr_instr(CSR_MINSTRETH, 5'd0, 3'd2), 2'd0, '0);
        send(csr_instr(CSR_MCYCLEH, 5'd0, 3'd3), 2'd0, '0);
        drain();

        bp_mode = 1'b1;
        repeat (80) random_op(3);
        drain();
        bp_mode = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        if (resp_valid || !req_ready) abort_run("DUT not idle at end of run");
        else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

// File: sim/tb_clock.sv
/*
 * Testbench clock source, 20 unit period
 */
module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

endmodule

// File: rtl/csr_top.sv
/*
 * CSR subsystem top
 * Decode, request FIFO, execute unit and CSR storage of one core
 */
module csr_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            req_valid,
    output logic                            req_ready,
    input  logic [31:0]                     req_instr,
    input  logic [csr_pkg::WID_BITS-1:0]    req_wid,
    input  logic [csr_pkg::XLEN-1:0]        req_rs1_data,
    input  logic                            fpu_flags_valid,
    input  logic [csr_pkg::WID_BITS-1:0]    fpu_flags_wid,
    input  logic [csr_pkg::FFLAGS_BITS-1:0] fpu_flags,
    input  logic [csr_pkg::WID_BITS-1:0]    fpu_frm_wid,
    output logic [csr_pkg::FRM_BITS-1:0]    fpu_frm,
    output logic                            resp_valid,
    input  logic                            resp_ready,
    output logic [csr_pkg::WID_BITS-1:0]    resp_wid,
    output logic [csr_pkg::XLEN-1:0]        resp_data,
    output logic                            resp_error
);
    import csr_pkg::*;

    logic                     dec_valid, dec_ready, dec_write;
    csr_op_e                  dec_op;
    logic [CSR_ADDR_BITS-1:0] dec_addr;
    logic [WID_BITS-1:0]      dec_wid;
    logic [XLEN-1:0]          dec_operand;

    logic                     q_valid, q_ready, q_write;
    csr_op_e                  q_op;
    logic [CSR_ADDR_BITS-1:0] q_addr;
    logic [WID_BITS-1:0]      q_wid;
    logic [XLEN-1:0]          q_operand;

    logic [CSR_ADDR_BITS-1:0] csr_addr;
    logic [WID_BITS-1:0]      csr_wid;
    logic [XLEN-1:0]          csr_rdata, csr_wdata;
    logic                     csr_addr_valid, csr_we, retire;

    csr_decode u_decode (.*);

    csr_req_fifo u_fifo (.*);

    csr_unit u_unit (.*);

    csr_data u_data (.*);

endmodule

// File: csr/csr_unit.sv
/*
 * CSR execute unit
 * Read-modify-write of one queued operation per cycle, registered response
 */
module csr_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              q_valid,
    output logic                              q_ready,
    input  csr_pkg::csr_op_e                  q_op,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0] q_addr,
    input  logic [csr_pkg::WID_BITS-1:0]      q_wid,
    input  logic [csr_pkg::XLEN-1:0]          q_operand,
    input  logic                              q_write,
    output logic [csr_pkg::CSR_ADDR_BITS-1:0] csr_addr,
    output logic [csr_pkg::WID_BITS-1:0]      csr_wid,
    input  logic [csr_pkg::XLEN-1:0]          csr_rdata,
    input  logic                              csr_addr_valid,
    output logic                              csr_we,
    output logic [csr_pkg::XLEN-1:0]          csr_wdata,
    output logic                              retire,
    output logic                              resp_valid,
    input  logic                              resp_ready,
    output logic [csr_pkg::WID_BITS-1:0]      resp_wid,
    output logic [csr_pkg::XLEN-1:0]          resp_data,
    output logic                              resp_error
);
    import csr_pkg::*;

    logic accept;
    logic read_only;
    logic error;

    // The head is looked up while it waits
    assign csr_addr = q_addr;
    assign csr_wid  = q_wid;

    assign q_ready   = !resp_valid || resp_ready;
    assign accept    = q_valid && q_ready;
    assign read_only = (q_addr[11:10] == 2'b11);
    assign error     = (q_op == CSR_OP_ILLEGAL) || !csr_addr_valid || (q_write && read_only);

    always_comb begin
        case (q_op)
            CSR_OP_RS, CSR_OP_RSI: csr_wdata = csr_rdata | q_operand;
            CSR_OP_RC, CSR_OP_RCI: csr_wdata = csr_rdata & ~q_operand;
            default:               csr_wdata = q_operand;
        endcase
    end

    assign csr_we = accept && !error && q_write;
    assign retire = accept && !error;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_valid <= 1'b0;
        end else if (q_ready) begin
            resp_valid <= q_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp_wid   <= q_wid;
            resp_data  <= error ? '0 : csr_rdata;
            resp_error <= error;
        end
    end

endmodule

// File: csr/csr_data.sv
/*
 * CSR storage and read block
 * Per-warp fcsr, mscratch, cycle and retire counters, identity reads,
 * FPU flag accumulation and address validation
 */
module csr_data (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0] csr_addr,
    input  logic [csr_pkg::WID_BITS-1:0]      csr_wid,
    output logic [csr_pkg::XLEN-1:0]          csr_rdata,
    output logic                              csr_addr_valid,
    input  logic                              csr_we,
    input  logic [csr_pkg::XLEN-1:0]          csr_wdata,
    input  logic                              retire,
    input  logic                              fpu_flags_valid,
    input  logic [csr_pkg::WID_BITS-1:0]      fpu_flags_wid,
    input  logic [csr_pkg::FFLAGS_BITS-1:0]   fpu_flags,
    input  logic [csr_pkg::WID_BITS-1:0]      fpu_frm_wid,
    output logic [csr_pkg::FRM_BITS-1:0]      fpu_frm
);
    import csr_pkg::*;

    localparam int FCSR_BITS = FRM_BITS + FFLAGS_BITS;

    logic [FCSR_BITS-1:0] fcsr   [NUM_WARPS];
    logic [FCSR_BITS-1:0] fcsr_n [NUM_WARPS];
    logic [XLEN-1:0]      mscratch;
    logic [63:0]          mcycle;
    logic [63:0]          minstret;

    // FPU flags first, a CSR write to the same warp wins
    always_comb begin
        fcsr_n = fcsr;
        if (fpu_flags_valid) begin
            fcsr_n[fpu_flags_wid][FFLAGS_BITS-1:0] =
                fcsr[fpu_flags_wid][FFLAGS_BITS-1:0] | fpu_flags;
        end
        if (csr_we) begin
            case (csr_addr)
                CSR_FFLAGS: fcsr_n[csr_wid][FFLAGS_BITS-1:0] = csr_wdata[FFLAGS_BITS-1:0];
                CSR_FRM:    fcsr_n[csr_wid][FCSR_BITS-1:FFLAGS_BITS] = csr_wdata[FRM_BITS-1:0];
                CSR_FCSR:   fcsr_n[csr_wid] = csr_wdata[FCSR_BITS-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_WARPS; i++) begin
                fcsr[i] <= '0;
            end
        end else begin
            fcsr <= fcsr_n;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mscratch <= MSCRATCH_RESET;
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (csr_we && csr_addr == CSR_MSCRATCH) begin
                mscratch <= csr_wdata;
            end
            mcycle <= mcycle + 64'd1;
            if (retire) begin
                minstret <= minstret + 64'd1;
            end
        end
    end

    assign fpu_frm = fcsr[fpu_frm_wid][FCSR_BITS-1:FFLAGS_BITS];

    always_comb begin
        csr_rdata      = '0;
        csr_addr_valid = 1'b1;
        case (csr_addr)
            CSR_FFLAGS:    csr_rdata = XLEN'(fcsr[csr_wid][FFLAGS_BITS-1:0]);
            CSR_FRM:       csr_rdata = XLEN'(fcsr[csr_wid][FCSR_BITS-1:FFLAGS_BITS]);
            CSR_FCSR:      csr_rdata = XLEN'(fcsr[csr_wid]);
            CSR_MSCRATCH:  csr_rdata = mscratch;
            CSR_MCYCLE:    csr_rdata = mcycle[31:0];
            CSR_MCYCLEH:   csr_rdata = mcycle[63:32];
            CSR_MINSTRET:  csr_rdata = minstret[31:0];
            CSR_MINSTRETH: csr_rdata = minstret[63:32];
            CSR_MISA:      csr_rdata = MISA_VALUE;
            CSR_MVENDORID: csr_rdata = VENDOR_ID;
            CSR_MARCHID:   csr_rdata = ARCH_ID;
            CSR_WARP_ID:   csr_rdata = XLEN'(csr_wid);
            CSR_CORE_ID:   csr_rdata = CORE_ID;
            CSR_NUM_WARPS: csr_rdata = XLEN'(NUM_WARPS);
            default:       csr_addr_valid = 1'b0;
        endcase
    end

endmodule

// File: rtl/csr_req_fifo.sv
/*
 * CSR request FIFO
 * Circular buffer of decoded CSR operations between decode and execute
 */
module csr_req_fifo (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              dec_valid,
    output logic                              dec_ready,
    input  csr_pkg::csr_op_e                  dec_op,
    input  logic [csr_pkg::CSR_ADDR_BITS-1:0] dec_addr,
    input  logic [csr_pkg::WID_BITS-1:0]      dec_wid,
    input  logic [csr_pkg::XLEN-1:0]          dec_operand,
    input  logic                              dec_write,
    output logic                              q_valid,
    input  logic                              q_ready,
    output csr_pkg::csr_op_e                  q_op,
    output logic [csr_pkg::CSR_ADDR_BITS-1:0] q_addr,
    output logic [csr_pkg::WID_BITS-1:0]      q_wid,
    output logic [csr_pkg::XLEN-1:0]          q_operand,
    output logic                              q_write
);
    import csr_pkg::*;

    csr_op_e                  op_mem      [REQ_FIFO_DEPTH];
    logic [CSR_ADDR_BITS-1:0] addr_mem    [REQ_FIFO_DEPTH];
    logic [WID_BITS-1:0]      wid_mem     [REQ_FIFO_DEPTH];
    logic [XLEN-1:0]          operand_mem [REQ_FIFO_DEPTH];
    logic                     write_mem   [REQ_FIFO_DEPTH];

    logic [REQ_PTR_BITS-1:0] wr_ptr;
    logic [REQ_PTR_BITS-1:0] rd_ptr;
    logic [REQ_CNT_BITS-1:0] count;
    logic                    full;
    logic                    push;
    logic                    pop;

    assign full    = (count == REQ_CNT_BITS'(REQ_FIFO_DEPTH));
    assign q_valid = (count != '0);
    // A full FIFO still takes a push while the head drains
    assign dec_ready = !full || q_ready;
    assign push      = dec_valid && dec_ready;
    assign pop       = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr]      <= dec_op;
            addr_mem[wr_ptr]    <= dec_addr;
            wid_mem[wr_ptr]     <= dec_wid;
            operand_mem[wr_ptr] <= dec_operand;
            write_mem[wr_ptr]   <= dec_write;
        end
    end

    assign q_op      = op_mem[rd_ptr];
    assign q_addr    = addr_mem[rd_ptr];
    assign q_wid     = wid_mem[rd_ptr];
    assign q_operand = operand_mem[rd_ptr];
    assign q_write   = write_mem[rd_ptr];

endmodule

// File: rtl/csr_decode.sv
/*
 * CSR decode stage
 * Classifies CSR instruction words into operations, one-entry output register
 */
module csr_decode (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  logic [31:0]                       req_instr,
    input  logic [csr_pkg::WID_BITS-1:0]      req_wid,
    input  logic [csr_pkg::XLEN-1:0]          req_rs1_data,
    output logic                              dec_valid,
    input  logic                              dec_ready,
    output csr_pkg::csr_op_e                  dec_op,
    output logic [csr_pkg::CSR_ADDR_BITS-1:0] dec_addr,
    output logic [csr_pkg::WID_BITS-1:0]      dec_wid,
    output logic [csr_pkg::XLEN-1:0]          dec_operand,
    output logic                              dec_write
);
    import csr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1_field;
    csr_op_e    op_n;
    logic       accept;

    assign opcode    = req_instr[6:0];
    assign funct3    = req_instr[14:12];
    assign rs1_field = req_instr[19:15];

    always_comb begin
        if (opcode != OPCODE_SYSTEM || funct3 == 3'd0 || funct3 == 3'd4) begin
            op_n = CSR_OP_ILLEGAL;
        end else begin
            op_n = csr_op_e'(funct3);
        end
    end

    assign req_ready = !dec_valid || dec_ready;
    assign accept    = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (req_ready) begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_op   <= op_n;
            dec_addr <= req_instr[31:20];
            dec_wid  <= req_wid;
            // Immediate forms take the zero-extended uimm
            dec_operand <= funct3[2] ? XLEN'(rs1_field) : req_rs1_data;
            // Set/clear with a zero source field only reads
            dec_write <= !funct3[1] || (rs1_field != 5'd0);
        end
    end

endmodule

// File: common/csr_pkg.sv
/*
 * CSR subsystem package
 * Widths, CSR addresses, identity constants and the CSR operation encoding
 */
package csr_pkg;

    localparam int XLEN           = 32;
    localparam int NUM_WARPS      = 4;
    localparam int WID_BITS       = 2;
    localparam int CSR_ADDR_BITS  = 12;
    localparam int FFLAGS_BITS    = 5;
    localparam int FRM_BITS       = 3;
    localparam int REQ_FIFO_DEPTH = 4;
    localparam int REQ_PTR_BITS   = $clog2(REQ_FIFO_DEPTH);
    localparam int REQ_CNT_BITS   = $clog2(REQ_FIFO_DEPTH + 1);

    // Identity values
    localparam logic [31:0] VENDOR_ID      = 32'h0000_0a5c;
    localparam logic [31:0] ARCH_ID        = 32'h0000_0002;
    localparam logic [31:0] MISA_VALUE     = 32'h4000_1120;
    localparam logic [31:0] CORE_ID        = 32'h0000_0000;
    localparam logic [31:0] MSCRATCH_RESET = 32'h0000_1000;

    localparam logic [11:0] CSR_FFLAGS    = 12'h001;
    localparam logic [11:0] CSR_FRM       = 12'h002;
    localparam logic [11:0] CSR_FCSR      = 12'h003;
    localparam logic [11:0] CSR_MISA      = 12'h301;
    localparam logic [11:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MCYCLEH   = 12'hB80;
    localparam logic [11:0] CSR_MINSTRETH = 12'hB82;
    localparam logic [11:0] CSR_WARP_ID   = 12'hCC0;
    localparam logic [11:0] CSR_CORE_ID   = 12'hCC1;
    localparam logic [11:0] CSR_MVENDORID = 12'hF11;
    localparam logic [11:0] CSR_MARCHID   = 12'hF12;
    localparam logic [11:0] CSR_NUM_WARPS = 12'hFC1;

    localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

    // Values match funct3 of the instruction
    typedef enum logic [2:0] {
        CSR_OP_ILLEGAL = 3'd0,
        CSR_OP_RW      = 3'd1,
        CSR_OP_RS      = 3'd2,
        CSR_OP_RC      = 3'd3,
        CSR_OP_RWI     = 3'd5,
        CSR_OP_RSI     = 3'd6,
        CSR_OP_RCI     = 3'd7
    } csr_op_e;

endpackage
